// File: flist.f
rv_pkg.sv
rv_regfile.sv
rv_stage_reg.sv
rv_alu.sv
rv_decode.sv
rv_execute.sv
rv_result.sv
rv_core_top.sv
tb_rv_core.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_rv_core
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= test passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: tb_rv_core.sv
`timescale 1ns/10ps

module tb_rv_core;
	import rv_pkg::*;

	localparam int          ACK_LIMIT   = 8;
	localparam int          DRAIN_LIMIT = 64;
	localparam logic [31:0] SEED        = 32'h2a86ecc7;

	typedef struct packed {
		logic [31:0] cycle;
		logic [4:0]  rd;
		logic [31:0] data;
		logic        chk; // Dropped instructions show rd only
	} wb_exp_t;

	logic        clk_i;
	logic        rst_ni;
	logic        wb_cyc_i;
	logic        wb_stb_i;
	logic        wb_we_i;
	logic [31:0] wb_dat_i;
	logic        wb_ack_o;
	logic [31:0] wb_dat_o;
	logic        wb_valid_o;
	logic [4:0]  wb_rd_o;
	logic [31:0] wb_data_o;

	logic [31:0] cyc;
	logic [31:0] mregs [0:31];
	logic [31:0] model_pc;
	wb_exp_t     exp_q [$];
	wb_exp_t     head;
	logic        head_valid;
	integer      seed;
	int          val_err;
	int          misc_err;

	rv_core_top rv_core_top_i (
		.clk_i      (clk_i),
		.rst_ni     (rst_ni),
		.wb_cyc_i   (wb_cyc_i),
		.wb_stb_i   (wb_stb_i),
		.wb_we_i    (wb_we_i),
		.wb_dat_i   (wb_dat_i),
		.wb_ack_o   (wb_ack_o),
		.wb_dat_o   (wb_dat_o),
		.wb_valid_o (wb_valid_o),
		.wb_rd_o    (wb_rd_o),
		.wb_data_o  (wb_data_o)
	);

	always #2 clk_i = ~clk_i;

	always @(posedge clk_i) cyc <= cyc + 32'd1;

	// ******************************************************************
	// Instruction encoding and reference model
	// ******************************************************************
	function automatic logic [31:0] r_type(input logic [2:0] f3, input logic alt,
		input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
		return {1'b0, alt, 5'd0, rs2, rs1, f3, rd, OPC_OP};
	endfunction

	function automatic logic [31:0] i_type(input logic [2:0] f3, input logic [11:0] imm,
		input logic [4:0] rd, input logic [4:0] rs1);
		return {imm, rs1, f3, rd, OPC_OP_IMM};
	endfunction

	function automatic logic [31:0] u_type(input logic [6:0] opc, input logic [19:0] imm,
		input logic [4:0] rd);
		return {imm, rd, opc};
	endfunction

	function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
		input logic [31:0] a, input logic [31:0] b);
		logic [4:0] sh;
		sh = b[4:0];
		case (f3)
			3'd0:    alu_ref = alt ? a - b : a + b;
			3'd1:    alu_ref = a << sh;
			3'd2:    alu_ref = {31'd0, (a[31] != b[31]) ? a[31] : (a < b)};
			3'd3:    alu_ref = {31'd0, a < b};
			3'd4:    alu_ref = a ^ b;
			3'd5:    alu_ref = alt ? (a >> sh) | ({32{a[31]}} & ~(32'hffffffff >> sh)) :
				a >> sh;
			3'd6:    alu_ref = a | b;
			default: alu_ref = a & b;
		endcase
	endfunction

	task automatic refresh_head();
		head_valid = exp_q.size() != 0;
		head       = '0;
		if (head_valid) head = exp_q[0];
	endtask

	// The model register file takes the new value at issue
	task automatic predict(input logic [31:0] instr, input logic [31:0] when);
		wb_exp_t     e;
		logic [31:0] a;
		logic [31:0] b;
		logic        we;
		a       = mregs[instr[19:15]];
		b       = mregs[instr[24:20]];
		we      = 1'b1;
		e.cycle = when;
		e.rd    = instr[11:7];
		e.chk   = 1'b1;
		case (instr[6:0])
			OPC_OP:     e.data = alu_ref(instr[14:12], instr[30], a, b);
			OPC_OP_IMM: e.data = alu_ref(instr[14:12], instr[30] && instr[14:12] == 3'd5, a,
				{{20{instr[31]}}, instr[31:20]});
			OPC_LUI:    e.data = {instr[31:12], 12'd0};
			OPC_AUIPC:  e.data = model_pc + {instr[31:12], 12'd0};
			default: begin
				e.data = '0;
				e.chk  = 1'b0;
				we     = 1'b0;
			end
		endcase
		if (we && e.rd != 5'd0) mregs[e.rd] = e.data;
		model_pc = model_pc + 32'd4;
		exp_q.push_back(e);
		refresh_head();
	endtask

	always @(negedge clk_i) begin
		if (wb_valid_o && exp_q.size() != 0) begin
			void'(exp_q.pop_front());
			refresh_head();
		end
	end

	// ******************************************************************
	// Wishbone master
	// ******************************************************************
	task automatic bus_cycle(input logic we, input logic [31:0] dat);
		int          tries;
		logic [31:0] start;
		tries = 0;
		@(negedge clk_i);
		wb_cyc_i = 1'b1;
		wb_stb_i = 1'b1;
		wb_we_i  = we;
		wb_dat_i = dat;
		start    = cyc;
		do begin
			@(posedge clk_i);
			tries++;
		end while (!wb_ack_o && tries < ACK_LIMIT);
		if (!wb_ack_o) begin
			misc_err++;
			$display("%0t: Wishbone cycle was never acknowledged", $time);
		end else if (we) begin
			predict(dat, start + 32'(tries) + 32'd2); // Two cycles after the accepting edge
		end
	endtask

	task automatic bus_write(input logic [31:0] instr);
		bus_cycle(1'b1, instr);
	endtask

	task automatic bus_read();
		bus_cycle(1'b0, 32'd0);
	endtask

	task automatic bus_idle();
		@(negedge clk_i);
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i  = 1'b0;
		wb_dat_i = '0;
	endtask

	task automatic wait_drain();
		int n;
		n = 0;
		bus_idle();
		while (exp_q.size() != 0 && n < DRAIN_LIMIT) begin
			@(negedge clk_i);
			n++;
		end
		if (exp_q.size() != 0) begin
			misc_err++;
			$display("%0t: writebacks still missing after %0d cycles", $time, DRAIN_LIMIT);
		end
	endtask

	// ******************************************************************
	// Checking
	// ******************************************************************
	ack_follows_strobe: assert property (@(negedge clk_i) disable iff (!rst_ni)
		wb_ack_o == (wb_cyc_i && wb_stb_i))
		else begin
			val_err++;
			$display("FAILED %0t wb_ack_o: expected %b, actual %b", $time,
				$sampled(wb_cyc_i && wb_stb_i), $sampled(wb_ack_o));
		end

	pc_read: assert property (@(negedge clk_i) disable iff (!rst_ni)
		wb_cyc_i && wb_stb_i && !wb_we_i |-> wb_dat_o == model_pc)
		else begin
			val_err++;
			$display("FAILED %0t wb_dat_o: expected %h, actual %h", $time,
				$sampled(model_pc), $sampled(wb_dat_o));
		end

	wb_expected: assert property (@(negedge clk_i) disable iff (!rst_ni)
		wb_valid_o |-> head_valid)
		else begin
			misc_err++;
			$display("%0t: writeback of x%0d with no instruction outstanding", $time,
				$sampled(wb_rd_o));
		end

	wb_latency: assert property (@(negedge clk_i) disable iff (!rst_ni)
		wb_valid_o && head_valid |-> cyc == head.cycle)
		else begin
			val_err++;
			$display("FAILED %0t wb_valid_o cycle: expected %0d, actual %0d", $time,
				$sampled(head.cycle), $sampled(cyc));
		end

	wb_dest: assert property (@(negedge clk_i) disable iff (!rst_ni)
		wb_valid_o && head_valid |-> wb_rd_o == head.rd)
		else begin
			val_err++;
			$display("FAILED %0t wb_rd_o: expected %0d, actual %0d", $time,
				$sampled(head.rd), $sampled(wb_rd_o));
		end

	wb_value: assert property (@(negedge clk_i) disable iff (!rst_ni)
		wb_valid_o && head_valid && head.chk |-> wb_data_o == head.data)
		else begin
			val_err++;
			$display("FAILED %0t wb_data_o: expected %h, actual %h", $time,
				$sampled(head.data), $sampled(wb_data_o));
		end

	// ******************************************************************
	// Stimulus
	// ******************************************************************
	initial begin
		logic [31:0] r;
		logic [11:0] imm;
		logic [6:0]  opc;
		logic        alt;
		seed       = SEED;
		clk_i      = 1'b0;
		rst_ni     = 1'b0;
		wb_cyc_i   = 1'b0;
		wb_stb_i   = 1'b0;
		wb_we_i    = 1'b0;
		wb_dat_i   = '0;
		cyc        = '0;
		model_pc   = '0;
		val_err    = 0;
		misc_err   = 0;
		head       = '0;
		head_valid = 1'b0;
		for (int i = 0; i < 32; i++) mregs[i] = '0;
		repeat (8) @(posedge clk_i);
		@(negedge clk_i);
		rst_ni = 1'b1;
		repeat (3) bus_idle();
		@(negedge clk_i);
		wb_cyc_i = 1'b1; // Cycle open with a write pending but no strobe
		wb_we_i  = 1'b1;
		wb_dat_i = i_type(3'd0, 12'h001, 5'd1, 5'd0);
		bus_read(); // Program counter starts at 0

		for (int i = 1; i < 32; i++) begin
			r = $random(seed);
			bus_write(u_type(OPC_LUI, r[31:12], 5'(i)));
			bus_write(i_type(3'd0, r[11:0], 5'(i), 5'(i)));
		end
		for (int k = 0; k < 50; k++) begin
			r = $random(seed);
			if (k < 10) r[3:0] = (k < 8) ? {1'b0, 3'(k)} : ((k == 8) ? 4'b1000 : 4'b1101);
			alt = r[3] && (r[2:0] == 3'd0 || r[2:0] == 3'd5); // SUB and SRA only
			bus_write(r_type(r[2:0], alt, r[8:4], r[13:9], r[18:14]));
			if (r[19]) bus_idle();
		end
		wait_drain();

		// Shifts and compares against a negative operand
		bus_write(u_type(OPC_LUI, 20'h80f0f, 5'd5));
		bus_write(i_type(3'd5, 12'h407, 5'd6, 5'd5));
		bus_write(i_type(3'd5, 12'h003, 5'd7, 5'd5));
		bus_write(i_type(3'd1, 12'h001, 5'd8, 5'd5));
		bus_write(i_type(3'd3, 12'hfff, 5'd9, 5'd5));
		bus_write(i_type(3'd2, 12'h800, 5'd10, 5'd5));
		for (int k = 0; k < 30; k++) begin
			r = $random(seed);
			case (r[2:0])
				3'd1:    imm = {7'd0, r[24:20]};
				3'd5:    imm = {1'b0, r[25], 5'd0, r[24:20]};
				default: imm = r[31:20];
			endcase
			bus_write(i_type(r[2:0], imm, r[12:8], r[17:13]));
		end
		wait_drain();

		for (int d = 1; d <= 3; d++) begin
			for (int k = 0; k < 12; k++) begin
				r = $random(seed);
				alt = r[3] && (r[2:0] == 3'd0 || r[2:0] == 3'd5);
				bus_write(r_type(r[2:0], alt, 5'(10 + k % d), 5'(10 + k % d),
					5'(10 + (k + d - 1) % d)));
			end
			wait_drain();
		end

		for (int k = 0; k < 8; k++) begin
			r = $random(seed);
			bus_write(u_type(r[0] ? OPC_AUIPC : OPC_LUI, r[31:12], r[5:1]));
		end
		bus_read();

		// Writes to x0 and dropped opcodes leave the registers alone
		bus_write(i_type(3'd0, 12'h123, 5'd0, 5'd1));
		bus_write(r_type(3'd0, 1'b0, 5'd0, 5'd2, 5'd3));
		bus_write(r_type(3'd0, 1'b0, 5'd14, 5'd0, 5'd4));
		bus_write({12'h7ff, 5'd1, 3'd2, 5'd12, 7'b0000011});
		bus_write({7'd0, 5'd2, 5'd1, 3'd0, 5'd15, 7'b1100011});
		bus_write(r_type(3'd6, 1'b0, 5'd16, 5'd12, 5'd15));
		for (int k = 0; k < 6; k++) begin
			r = $random(seed);
			opc = {r[6:2], 2'b11};
			if (opc == OPC_OP || opc == OPC_OP_IMM || opc == OPC_LUI || opc == OPC_AUIPC)
				opc = 7'b0001111;
			bus_write({r[31:7], opc});
			bus_write(r_type(3'd0, 1'b0, 5'd17, r[11:7], r[19:15]));
		end
		wait_drain();
		bus_read();
		bus_idle();
		repeat (2) @(negedge clk_i);
		@(posedge clk_i);
		$display("errors: %0d value, %0d other", val_err, misc_err);
		if (val_err == 0 && misc_err == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

// File: rv_core_top.sv
`timescale 1ns/10ps

module rv_core_top (
	input  logic                      clk_i,
	input  logic                      rst_ni,
	input  logic                      wb_cyc_i,
	input  logic                      wb_stb_i,
	input  logic                      wb_we_i,
	input  logic [rv_pkg::XLEN-1:0]   wb_dat_i,
	output logic                      wb_ack_o,
	output logic [rv_pkg::XLEN-1:0]   wb_dat_o,
	output logic                      wb_valid_o,
	output logic [rv_pkg::REG_AW-1:0] wb_rd_o,
	output logic [rv_pkg::XLEN-1:0]   wb_data_o
);
	import rv_pkg::*;

	logic              dec_valid;
	dec_ex_t           dec;
	logic              ex_in_valid;
	dec_ex_t           ex_in;
	logic              ex_valid;
	ex_res_t           ex_res;
	logic              res_in_valid;
	ex_res_t           res_in;
	logic              rf_we;
	logic [REG_AW-1:0] rf_addr;
	logic [XLEN-1:0]   rf_data;

	rv_decode rv_decode_i (
		.clk_i       (clk_i),
		.rst_ni      (rst_ni),
		.wb_cyc_i    (wb_cyc_i),
		.wb_stb_i    (wb_stb_i),
		.wb_we_i     (wb_we_i),
		.wb_dat_i    (wb_dat_i),
		.wb_ack_o    (wb_ack_o),
		.wb_dat_o    (wb_dat_o),
		.rf_we_i     (rf_we),
		.rf_addr_i   (rf_addr),
		.rf_data_i   (rf_data),
		.dec_valid_o (dec_valid),
		.dec_o       (dec)
	);

	rv_stage_reg #(.payload_t(dec_ex_t)) dec_ex_reg_i (
		.clk_i   (clk_i),
		.rst_ni  (rst_ni),
		.valid_i (dec_valid),
		.data_i  (dec),
		.valid_o (ex_in_valid),
		.data_o  (ex_in)
	);

	// Result stage write data is forwarded to the instruction right behind it
	rv_execute rv_execute_i (
		.valid_i     (ex_in_valid),
		.dec_i       (ex_in),
		.fwd_valid_i (res_in_valid),
		.fwd_we_i    (res_in.reg_we),
		.fwd_rd_i    (res_in.rd),
		.fwd_data_i  (rf_data),
		.valid_o     (ex_valid),
		.res_o       (ex_res)
	);

	rv_stage_reg #(.payload_t(ex_res_t)) ex_res_reg_i (
		.clk_i   (clk_i),
		.rst_ni  (rst_ni),
		.valid_i (ex_valid),
		.data_i  (ex_res),
		.valid_o (res_in_valid),
		.data_o  (res_in)
	);

	rv_result rv_result_i (
		.valid_i    (res_in_valid),
		.res_i      (res_in),
		.rf_we_o    (rf_we),
		.rf_addr_o  (rf_addr),
		.rf_data_o  (rf_data),
		.wb_valid_o (wb_valid_o),
		.wb_rd_o    (wb_rd_o),
		.wb_data_o  (wb_data_o)
	);

endmodule

// File: rv_result.sv
`timescale 1ns/10ps

module rv_result (
	input  logic                      valid_i,
	input  rv_pkg::ex_res_t           res_i,
	output logic                      rf_we_o,
	output logic [rv_pkg::REG_AW-1:0] rf_addr_o,
	output logic [rv_pkg::XLEN-1:0]   rf_data_o,
	output logic                      wb_valid_o,
	output logic [rv_pkg::REG_AW-1:0] wb_rd_o,
	output logic [rv_pkg::XLEN-1:0]   wb_data_o
);
	import rv_pkg::*;

	assign rf_data_o = (res_i.res_sel == RES_IMM) ? res_i.imm : res_i.alu_res;
	assign rf_addr_o = res_i.rd;
	assign rf_we_o   = valid_i && res_i.reg_we && res_i.rd != '0; // x0 stays zero

	// Bubbles never report, dropped instructions report without a write
	assign wb_valid_o = valid_i;
	assign wb_rd_o    = res_i.rd;
	assign wb_data_o  = rf_data_o;

	always_comb begin
		if (rf_we_o) begin
			no_x0_write: assert final (rf_addr_o != '0)
				else $error("register file write to x0");
		end
	end

endmodule

// File: rv_execute.sv
`timescale 1ns/10ps

module rv_execute (
	input  logic                      valid_i,
	input  rv_pkg::dec_ex_t           dec_i,
	input  logic                      fwd_valid_i,
	input  logic                      fwd_we_i,
	input  logic [rv_pkg::REG_AW-1:0] fwd_rd_i,
	input  logic [rv_pkg::XLEN-1:0]   fwd_data_i,
	output logic                      valid_o,
	output rv_pkg::ex_res_t           res_o
);
	import rv_pkg::*;

	logic            fwd_live;
	logic            fwd_rs1;
	logic            fwd_rs2;
	logic [XLEN-1:0] rs1_val;
	logic [XLEN-1:0] rs2_val;
	logic [XLEN-1:0] op_a;
	logic [XLEN-1:0] op_b;
	logic [XLEN-1:0] alu_res;

	// ******************************************************************
	// Forwarding from the instruction now in the result stage
	// ******************************************************************
	// The instruction two ahead is already covered by the register file bypass
	assign fwd_live = fwd_valid_i && fwd_we_i && fwd_rd_i != '0;
	assign fwd_rs1  = fwd_live && fwd_rd_i == dec_i.rs1_addr;
	assign fwd_rs2  = fwd_live && fwd_rd_i == dec_i.rs2_addr;

	assign rs1_val = fwd_rs1 ? fwd_data_i : dec_i.rs1_val;
	assign rs2_val = fwd_rs2 ? fwd_data_i : dec_i.rs2_val;

	// ******************************************************************
	// Operand selection and ALU
	// ******************************************************************
	assign op_a = dec_i.a_sel_pc  ? dec_i.pc  : rs1_val; // AUIPC adds to pc
	assign op_b = dec_i.b_sel_imm ? dec_i.imm : rs2_val;

	rv_alu rv_alu_i (
		.a_i      (op_a),
		.b_i      (op_b),
		.op_i     (dec_i.alu_op),
		.result_o (alu_res)
	);

	always_comb begin
		res_o         = '0;
		res_o.alu_res = alu_res;
		res_o.imm     = dec_i.imm;
		res_o.res_sel = dec_i.res_sel;
		res_o.rd      = dec_i.rd;
		res_o.reg_we  = dec_i.reg_we;
	end

	assign valid_o = valid_i;

	// A pc-relative operand is only useful when the ALU result is written back
	always_comb begin
		if (valid_i && dec_i.a_sel_pc) begin
			pc_op_uses_alu: assert final (dec_i.res_sel == RES_ALU)
				else $error("pc operand selected while the immediate is the result");
		end
	end

endmodule

// File: rv_decode.sv
`timescale 1ns/10ps

module rv_decode (
	input  logic                      clk_i,
	input  logic                      rst_ni,
	input  logic                      wb_cyc_i,
	input  logic                      wb_stb_i,
	input  logic                      wb_we_i,
	input  logic [rv_pkg::XLEN-1:0]   wb_dat_i,
	output logic                      wb_ack_o,
	output logic [rv_pkg::XLEN-1:0]   wb_dat_o,
	input  logic                      rf_we_i,
	input  logic [rv_pkg::REG_AW-1:0] rf_addr_i,
	input  logic [rv_pkg::XLEN-1:0]   rf_data_i,
	output logic                      dec_valid_o,
	output rv_pkg::dec_ex_t           dec_o
);
	import rv_pkg::*;

	logic              wr_accept;
	logic [XLEN-1:0]   pc_q;
	logic              issue_q;
	logic [XLEN-1:0]   ir_q;
	logic [XLEN-1:0]   ir_pc_q;

	logic [6:0]        opcode;
	logic [2:0]        funct3;
	logic              alt_op;
	logic [REG_AW-1:0] rs1_addr;
	logic [REG_AW-1:0] rs2_addr;
	logic [XLEN-1:0]   rs1_val;
	logic [XLEN-1:0]   rs2_val;
	logic [XLEN-1:0]   imm_i;
	logic [XLEN-1:0]   imm_u;
	alu_op_e           alu_op;

	// ******************************************************************
	// Wishbone slave and program counter
	// ******************************************************************
	assign wb_ack_o  = wb_cyc_i & wb_stb_i; // Zero wait states
	assign wb_dat_o  = pc_q;
	assign wr_accept = wb_ack_o & wb_we_i;

	always_ff @(posedge clk_i, negedge rst_ni) begin
		if (!rst_ni) begin
			pc_q    <= '0;
			issue_q <= 1'b0;
		end else begin
			issue_q <= wr_accept;
			if (wr_accept) pc_q <= pc_q + XLEN'(4);
		end
	end

	always_ff @(posedge clk_i) begin
		if (wr_accept) begin
			ir_q    <= wb_dat_i;
			ir_pc_q <= pc_q;
		end
	end

	// ******************************************************************
	// Instruction decode
	// ******************************************************************
	assign opcode   = ir_q[6:0];
	assign funct3   = ir_q[14:12];
	assign alt_op   = ir_q[30]; // funct7 bit that selects SUB and SRA
	assign rs1_addr = ir_q[19:15];
	assign rs2_addr = ir_q[24:20];
	assign imm_i    = {{20{ir_q[31]}}, ir_q[31:20]};
	assign imm_u    = {ir_q[31:12], 12'b0};

	always_comb begin
		case (funct3)
			3'b000:  alu_op = (opcode == OPC_OP && alt_op) ? ALU_SUB : ALU_ADD;
			3'b001:  alu_op = ALU_SLL;
			3'b010:  alu_op = ALU_SLT;
			3'b011:  alu_op = ALU_SLTU;
			3'b100:  alu_op = ALU_XOR;
			3'b101:  alu_op = alt_op ? ALU_SRA : ALU_SRL;
			3'b110:  alu_op = ALU_OR;
			default: alu_op = ALU_AND;
		endcase
	end

	rv_regfile rv_regfile_i (
		.clk_i      (clk_i),
		.rst_ni     (rst_ni),
		.rs1_addr_i (rs1_addr),
		.rs2_addr_i (rs2_addr),
		.rs1_data_o (rs1_val),
		.rs2_data_o (rs2_val),
		.we_i       (rf_we_i),
		.wr_addr_i  (rf_addr_i),
		.wr_data_i  (rf_data_i)
	);

	always_comb begin
		dec_o           = '0;
		dec_o.rs1_addr  = rs1_addr;
		dec_o.rs2_addr  = rs2_addr;
		dec_o.rs1_val   = rs1_val;
		dec_o.rs2_val   = rs2_val;
		dec_o.imm       = imm_i;
		dec_o.pc        = ir_pc_q;
		dec_o.alu_op    = ALU_ADD;
		dec_o.res_sel   = RES_ALU;
		dec_o.rd        = ir_q[11:7];
		case (opcode)
			OPC_OP: begin
				dec_o.alu_op = alu_op;
				dec_o.reg_we = 1'b1;
			end
			OPC_OP_IMM: begin
				dec_o.alu_op    = alu_op; // Shift amount sits in the low immediate bits
				dec_o.b_sel_imm = 1'b1;
				dec_o.reg_we    = 1'b1;
			end
			OPC_LUI: begin
				dec_o.imm     = imm_u;
				dec_o.res_sel = RES_IMM;
				dec_o.reg_we  = 1'b1;
			end
			OPC_AUIPC: begin
				dec_o.imm       = imm_u;
				dec_o.a_sel_pc  = 1'b1;
				dec_o.b_sel_imm = 1'b1;
				dec_o.reg_we    = 1'b1;
			end
			default: dec_o.reg_we = 1'b0; // Retires without a register write
		endcase
	end

	assign dec_valid_o = issue_q;

	ack_needs_strobe: assert property (@(posedge clk_i) disable iff (!rst_ni)
		wb_ack_o |-> wb_stb_i && wb_cyc_i);

endmodule

// File: rv_alu.sv
`timescale 1ns/10ps

module rv_alu (
	input  logic [rv_pkg::XLEN-1:0] a_i,
	input  logic [rv_pkg::XLEN-1:0] b_i,
	input  rv_pkg::alu_op_e         op_i,
	output logic [rv_pkg::XLEN-1:0] result_o
);
	import rv_pkg::*;

	logic [4:0] shamt;
	logic       lt_signed;
	logic       lt_unsigned;

	assign shamt       = b_i[4:0];
	assign lt_signed   = $signed(a_i) < $signed(b_i);
	assign lt_unsigned = a_i < b_i;

	always_comb begin
		case (op_i)
			ALU_ADD:  result_o = a_i + b_i;
			ALU_SUB:  result_o = a_i - b_i;
			ALU_SLL:  result_o = a_i << shamt;
			ALU_SLT:  result_o = {{(XLEN-1){1'b0}}, lt_signed};
			ALU_SLTU: result_o = {{(XLEN-1){1'b0}}, lt_unsigned};
			ALU_XOR:  result_o = a_i ^ b_i;
			ALU_SRL:  result_o = a_i >> shamt;
			ALU_SRA:  result_o = $unsigned($signed(a_i) >>> shamt);
			ALU_OR:   result_o = a_i | b_i;
			ALU_AND:  result_o = a_i & b_i;
			default:  result_o = '0;
		endcase
	end

endmodule

// File: rv_stage_reg.sv
`timescale 1ns/10ps

module rv_stage_reg #(
	parameter type payload_t = logic
) (
	input  logic     clk_i,
	input  logic     rst_ni,
	input  logic     valid_i,
	input  payload_t data_i,
	output logic     valid_o,
	output payload_t data_o
);

	logic     valid_q;
	payload_t data_q;

	always_ff @(posedge clk_i, negedge rst_ni) begin
		if (!rst_ni) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= valid_i; // A cycle without input becomes a bubble
		end
	end

	always_ff @(posedge clk_i) begin
		if (valid_i) data_q <= data_i;
	end

	assign valid_o = valid_q;
	assign data_o  = data_q;

endmodule

// File: rv_regfile.sv
`timescale 1ns/10ps

module rv_regfile (
	input  logic                      clk_i,
	input  logic                      rst_ni,
	input  logic [rv_pkg::REG_AW-1:0] rs1_addr_i,
	input  logic [rv_pkg::REG_AW-1:0] rs2_addr_i,
	output logic [rv_pkg::XLEN-1:0]   rs1_data_o,
	output logic [rv_pkg::XLEN-1:0]   rs2_data_o,
	input  logic                      we_i,
	input  logic [rv_pkg::REG_AW-1:0] wr_addr_i,
	input  logic [rv_pkg::XLEN-1:0]   wr_data_i
);
	import rv_pkg::*;

	logic [XLEN-1:0] regs_q [1:31]; // x0 has no storage

	always_ff @(posedge clk_i, negedge rst_ni) begin
		if (!rst_ni) begin
			for (int i = 1; i < 32; i++) begin
				regs_q[i] <= '0;
			end
		end else if (we_i && wr_addr_i != '0) begin
			regs_q[wr_addr_i] <= wr_data_i;
		end
	end

	// A read of the register being written sees the new value in the same cycle
	assign rs1_data_o = (rs1_addr_i == '0) ? '0 :
		(we_i && wr_addr_i == rs1_addr_i) ? wr_data_i : regs_q[rs1_addr_i];
	assign rs2_data_o = (rs2_addr_i == '0) ? '0 :
		(we_i && wr_addr_i == rs2_addr_i) ? wr_data_i : regs_q[rs2_addr_i];

endmodule

// File: rv_pkg.sv
package rv_pkg;

	localparam int XLEN   = 32;
	localparam int REG_AW = 5;

	// ******************************************************************
	// Major opcodes of the supported RV32I instructions
	// ******************************************************************
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND
	} alu_op_e;

	typedef enum logic {
		RES_ALU,
		RES_IMM // LUI writes the immediate directly
	} res_sel_e;

	// Decode to execute
	typedef struct packed {
		logic [REG_AW-1:0] rs1_addr;
		logic [REG_AW-1:0] rs2_addr;
		logic [XLEN-1:0]   rs1_val;
		logic [XLEN-1:0]   rs2_val;
		logic [XLEN-1:0]   imm;
		logic [XLEN-1:0]   pc;
		alu_op_e           alu_op;
		logic              a_sel_pc;
		logic              b_sel_imm;
		res_sel_e          res_sel;
		logic [REG_AW-1:0] rd;
		logic              reg_we;
	} dec_ex_t;

	// Execute to result
	typedef struct packed {
		logic [XLEN-1:0]   alu_res;
		logic [XLEN-1:0]   imm;
		res_sel_e          res_sel;
		logic [REG_AW-1:0] rd;
		logic              reg_we;
	} ex_res_t;

endpackage
